// ==== src.f ====
mci_pkg.sv
mci_csr.sv
mci_mtime.sv
mci_err_agg.sv
mci_fw_upd_fsm.sv
mci_top.sv
mci_chk.sv
tb_mci.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mci
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = all tests passed
FAIL_MSG   = tests failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_mci.sv ====
`timescale 1ns/1ps
// MCI control register block testbench
// Directed tests over the register port: register readback, machine timer,
// fatal and non-fatal error reporting, firmware update requests and the
// watchdog serviced pulse. Prints one line per test and a closing count.
module tb_mci import mci_pkg::*; ();

logic                  clk;
logic                  mci_rst_b;
logic                  req;
logic                  wr;
logic [mci_addr_w-1:0] addr;
logic [mci_data_w-1:0] wdata;
logic [mci_strb_w-1:0] wstrb;
logic [mci_data_w-1:0] rdata;
logic                  err;
logic                  t1_timeout;
logic                  t2_timeout;
logic                  t1_timeout_p;
logic                  t2_timeout_p;
logic                  wdt_timer1_timeout_serviced;
logic                  wdt_timer2_timeout_serviced;
logic                  cptra_error_fatal;
logic                  cptra_error_non_fatal;
logic                  nmi_intr;
logic                  mcu_sram_single_ecc_error;
logic                  mcu_sram_double_ecc_error;
logic                  mcu_sram_fw_exec_region_lock;
logic                  mci_intr;
logic                  mcu_timer_int;
logic                  mci_error_fatal;
logic                  mci_error_non_fatal;

// Outputs that a bounded wait can watch
typedef enum {w_timer_int, w_mci_intr, w_non_fatal} watch_e;

int          errors    = 0;
int          checks    = 0;
int          tests_run = 0;
logic [31:0] lcg_state = 32'd54;

mci_top dut0 (.*);

// 100 ns clock
initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Strobe to bit enable, one strobe per byte lane
function automatic logic [31:0] byte_mask(input logic [3:0] s);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
        m[b*8 +: 8] = s[b] ? 8'hFF : 8'h00;
    end
    return m;
endfunction

function automatic logic watched_level(input watch_e w);
    case (w)
        w_timer_int: return mcu_timer_int;
        w_mci_intr:  return mci_intr;
        default:     return mci_error_non_fatal;
    endcase
endfunction

task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
        $display("ERR %s: expected %08h, actual %08h", name, exp, act);
        errors++;
    end
endtask

// Polls at the falling edge until the level shows up or the limit runs out
task automatic wait_level(input watch_e w, input logic level, input int limit,
                          input string what);
    int n;
    n = 0;
    while (watched_level(w) !== level && n < limit) begin
        @(negedge clk);
        n++;
    end
    checks++;
    assert (watched_level(w) === level) else begin
        $display("Timeout after %0d cycles waiting for %s", limit, what);
        errors++;
    end
endtask

task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
        $display("%-12s ok", name);
    end else begin
        $display("%-12s FAILED with %0d errors", name, errors - err_start);
    end
endtask

// Single-cycle request, driven at the rising edge
task automatic bus_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] s);
    @(posedge clk);
    req   <= 1'b1;
    wr    <= 1'b1;
    addr  <= a;
    wdata <= d;
    wstrb <= s;
    @(posedge clk);
    req   <= 1'b0;
    wr    <= 1'b0;
endtask

// Read data and err are combinational, sampled mid-cycle
task automatic bus_read(input logic [7:0] a, output logic [31:0] d, output logic e);
    @(posedge clk);
    req  <= 1'b1;
    wr   <= 1'b0;
    addr <= a;
    @(negedge clk);
    d = rdata;
    e = err;
    @(posedge clk);
    req <= 1'b0;
endtask

//////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////
task automatic reset_values();
    int err_start;
    err_start = errors;
    @(negedge clk);
    check_eq("reset: mci_intr", 32'h0, 32'(mci_intr));
    check_eq("reset: mcu_timer_int", 32'h0, 32'(mcu_timer_int));
    check_eq("reset: mci_error_fatal", 32'h0, 32'(mci_error_fatal));
    check_eq("reset: mci_error_non_fatal", 32'h0, 32'(mci_error_non_fatal));
    check_eq("reset: wdt serviced", 32'h0,
             32'({wdt_timer2_timeout_serviced, wdt_timer1_timeout_serviced}));
    report_test("reset", err_start);
endtask

task automatic registers_rw();
    logic [7:0]  regs [3];
    logic [31:0] width_mask [3];
    logic [31:0] expv [3];
    logic [31:0] data;
    logic [31:0] tmp;
    logic [31:0] rd;
    logic        rerr;
    int          err_start;
    err_start  = errors;
    regs       = '{fw_fatal_mask, fw_non_fatal_mask, intr_en};
    width_mask = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_000F};
    expv       = '{32'h0, 32'h0, 32'h0};
    for (int round = 0; round < 2; round++) begin
        for (int i = 0; i < 3; i++) begin
            data = lcg_next();
            tmp  = lcg_next();
            // Only strobed bytes change
            expv[i] = (expv[i] & ~byte_mask(tmp[19:16])) | (data & byte_mask(tmp[19:16]));
            bus_write(regs[i], data, tmp[19:16]);
            bus_read(regs[i], rd, rerr);
            check_eq("registers: readback", expv[i] & width_mask[i], rd);
            check_eq("registers: err on mapped read", 32'h0, 32'(rerr));
        end
    end
    bus_read(8'h40, rd, rerr);
    check_eq("registers: err at 0x40", 32'h1, 32'(rerr));
    bus_read(8'h05, rd, rerr);
    check_eq("registers: err at unaligned 0x05", 32'h1, 32'(rerr));
    report_test("registers", err_start);
endtask

task automatic timer_compare();
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] rd;
    logic        rerr;
    int          err_start;
    err_start = errors;
    // Back to back reads are two edges apart
    bus_read(mtime_l, v1, rerr);
    bus_read(mtime_l, v2, rerr);
    check_eq("timer: mtime advance", v1 + 32'd2, v2);
    bus_write(mtime_h, 32'h1, 4'hF);
    bus_write(mtimecmp_h, 32'h1, 4'hF);
    bus_read(mtime_h, rd, rerr);
    check_eq("timer: mtime_h after write", 32'h1, rd);
    bus_read(mtime_l, v1, rerr);
    bus_write(mtimecmp_l, v1 + 32'd50, 4'hF);
    @(negedge clk);
    check_eq("timer: interrupt before compare", 32'h0, 32'(mcu_timer_int));
    wait_level(w_timer_int, 1'b1, 200, "mcu_timer_int to rise");
    // Count drops below compare again
    bus_write(mtime_h, 32'h0, 4'hF);
    @(negedge clk);
    check_eq("timer: interrupt after mtime_h clear", 32'h0, 32'(mcu_timer_int));
    report_test("timer", err_start);
endtask

task automatic fatal_errors();
    logic [31:0] rd;
    logic        rerr;
    int          err_start;
    err_start = errors;
    check_eq("fatal: low at start", 32'h0, 32'(mci_error_fatal));
    bus_write(fw_fatal_mask, 32'h1, 4'hF);
    bus_write(fw_err_fatal, 32'h1, 4'h1);
    @(negedge clk);
    check_eq("fatal: masked bit", 32'h0, 32'(mci_error_fatal));
    bus_read(fw_err_fatal, rd, rerr);
    check_eq("fatal: fw_err_fatal masked bit", 32'h1, rd);
    bus_write(fw_err_fatal, 32'h10, 4'h1);
    @(negedge clk);
    check_eq("fatal: unmasked new bit", 32'h1, 32'(mci_error_fatal));
    // W1C of bit4, output stays sticky
    bus_write(fw_err_fatal, 32'h10, 4'h1);
    bus_read(fw_err_fatal, rd, rerr);
    check_eq("fatal: fw_err_fatal after clear", 32'h1, rd);
    @(negedge clk);
    check_eq("fatal: sticky after clear", 32'h1, 32'(mci_error_fatal));
    @(posedge clk);
    nmi_intr <= 1'b1;
    @(posedge clk);
    nmi_intr <= 1'b0;
    bus_read(hw_err_fatal, rd, rerr);
    check_eq("fatal: hw_err_fatal nmi bit", 32'h2, rd);
    report_test("fatal", err_start);
endtask

task automatic non_fatal_errors();
    logic [31:0] rd;
    logic        rerr;
    int          err_start;
    err_start = errors;
    @(negedge clk);
    check_eq("non-fatal: low at start", 32'h0, 32'(mci_error_non_fatal));
    @(posedge clk);
    cptra_error_non_fatal <= 1'b1;
    wait_level(w_non_fatal, 1'b1, 10, "mci_error_non_fatal to rise");
    bus_read(agg_err, rd, rerr);
    check_eq("non-fatal: agg_err set", 32'h2, rd);
    @(posedge clk);
    cptra_error_non_fatal <= 1'b0;
    // Let the two synchronizer flops drain before the clear
    repeat (4) @(posedge clk);
    bus_write(agg_err, 32'h2, 4'h1);
    wait_level(w_non_fatal, 1'b0, 10, "mci_error_non_fatal to fall");
    bus_read(agg_err, rd, rerr);
    check_eq("non-fatal: agg_err cleared", 32'h0, rd);
    report_test("non-fatal", err_start);
endtask

task automatic fw_update_req();
    logic [31:0] rd;
    logic        rerr;
    int          err_start;
    err_start = errors;
    bus_write(intr_en, 32'h4, 4'h1);
    @(posedge clk);
    mcu_sram_fw_exec_region_lock <= 1'b1;
    wait_level(w_mci_intr, 1'b1, 10, "mci_intr after first lock rise");
    bus_read(intr_sts, rd, rerr);
    check_eq("fw update: first lock rise", 32'h4, rd);
    bus_write(intr_sts, 32'h4, 4'h1);
    bus_read(intr_sts, rd, rerr);
    check_eq("fw update: status cleared", 32'h0, rd);
    // Hitless update starts on the lock fall
    @(posedge clk);
    mcu_sram_fw_exec_region_lock <= 1'b0;
    wait_level(w_mci_intr, 1'b1, 10, "mci_intr after lock fall");
    bus_read(intr_sts, rd, rerr);
    check_eq("fw update: lock fall", 32'h4, rd);
    bus_write(intr_sts, 32'h4, 4'h1);
    @(posedge clk);
    mcu_sram_fw_exec_region_lock <= 1'b1;
    repeat (6) @(posedge clk);
    bus_read(intr_sts, rd, rerr);
    check_eq("fw update: second lock rise", 32'h0, rd);
    @(negedge clk);
    check_eq("fw update: mci_intr after re-lock", 32'h0, 32'(mci_intr));
    report_test("fw update", err_start);
endtask

task automatic watchdog_service();
    logic [31:0] rd;
    logic        rerr;
    logic        seen1;
    logic        seen2;
    int          err_start;
    err_start = errors;
    // Both timeouts pending, only t1 gets cleared
    @(posedge clk);
    t1_timeout_p <= 1'b1;
    t2_timeout_p <= 1'b1;
    @(posedge clk);
    t1_timeout_p <= 1'b0;
    t2_timeout_p <= 1'b0;
    bus_read(intr_sts, rd, rerr);
    check_eq("watchdog: t1 and t2 status", 32'h3, rd);
    @(posedge clk);
    t2_timeout <= 1'b1;
    bus_read(wdt_status, rd, rerr);
    check_eq("watchdog: wdt_status t2", 32'h2, rd);
    bus_write(intr_sts, 32'h1, 4'h1);
    seen1 = 1'b0;
    seen2 = 1'b0;
    for (int c = 0; c < 3; c++) begin
        @(negedge clk);
        seen1 = seen1 | wdt_timer1_timeout_serviced;
        seen2 = seen2 | wdt_timer2_timeout_serviced;
    end
    check_eq("watchdog: t1 serviced pulse", 32'h1, 32'(seen1));
    check_eq("watchdog: no t2 serviced pulse", 32'h0, 32'(seen2));
    bus_read(intr_sts, rd, rerr);
    check_eq("watchdog: t2 status kept", 32'h2, rd);
    report_test("watchdog", err_start);
endtask

//////////////////////////////////////////////////
// Sequence
//////////////////////////////////////////////////
initial begin
    mci_rst_b                    = 1'b0;
    req                          = 1'b0;
    wr                           = 1'b0;
    addr                         = '0;
    wdata                        = '0;
    wstrb                        = '0;
    t1_timeout                   = 1'b0;
    t2_timeout                   = 1'b0;
    t1_timeout_p                 = 1'b0;
    t2_timeout_p                 = 1'b0;
    cptra_error_fatal            = 1'b0;
    cptra_error_non_fatal        = 1'b0;
    nmi_intr                     = 1'b0;
    mcu_sram_single_ecc_error    = 1'b0;
    mcu_sram_double_ecc_error    = 1'b0;
    mcu_sram_fw_exec_region_lock = 1'b0;
    repeat (8) @(posedge clk);
    mci_rst_b <= 1'b1;
    @(posedge clk);
    reset_values();
    registers_rw();
    timer_compare();
    fatal_errors();
    non_fatal_errors();
    fw_update_req();
    watchdog_service();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

// ==== mci_chk.sv ====
`timescale 1ns/1ps
// MCI top level property checks
// Watches the register port error flag, the sticky fatal output, the
// single-cycle reset request and the cause of each watchdog serviced pulse
module mci_chk import mci_pkg::*; (
    input logic                  clk,
    input logic                  mci_rst_b,
    input logic                  req,
    input logic                  wr,
    input logic [mci_addr_w-1:0] addr,
    input logic [mci_data_w-1:0] wdata,
    input logic [mci_strb_w-1:0] wstrb,
    input logic                  err,
    input logic                  mci_error_fatal,
    input logic                  rst_req,
    input logic                  wdt_timer1_timeout_serviced,
    input logic                  wdt_timer2_timeout_serviced
);

//////////////////////////////////////////////////
// Register port
//////////////////////////////////////////////////

// Mapped offsets are word aligned and end at wdt_status
err_mapped_a: assert property (@(posedge clk) disable iff (!mci_rst_b)
    err == (req && (addr[1:0] != 2'b00 || addr > wdt_status)))
    else $error("err wrong for offset %02h", addr);

// Fatal is sticky until reset
fatal_sticky_a: assert property (@(posedge clk) disable iff (!mci_rst_b)
    !$fell(mci_error_fatal))
    else $error("mci_error_fatal dropped outside reset");

// Reset request lasts one cycle
rst_req_pulse_a: assert property (@(posedge clk) disable iff (!mci_rst_b)
    rst_req |=> !rst_req)
    else $error("rst_req held longer than one cycle");

// Serviced pulse only after a W1C write of that status bit
wdt1_pulse_a: assert property (@(posedge clk) disable iff (!mci_rst_b)
    wdt_timer1_timeout_serviced |->
        $past(req && wr && addr == intr_sts && wdata[intr_wdt1_bit] && wstrb[0]))
    else $error("timer1 serviced without a status clear");
wdt2_pulse_a: assert property (@(posedge clk) disable iff (!mci_rst_b)
    wdt_timer2_timeout_serviced |->
        $past(req && wr && addr == intr_sts && wdata[intr_wdt2_bit] && wstrb[0]))
    else $error("timer2 serviced without a status clear");

endmodule

bind mci_top mci_chk u_chk (
    .clk                         (clk),
    .mci_rst_b                   (mci_rst_b),
    .req                         (req),
    .wr                          (wr),
    .addr                        (addr),
    .wdata                       (wdata),
    .wstrb                       (wstrb),
    .err                         (err),
    .mci_error_fatal             (mci_error_fatal),
    .rst_req                     (rst_req),
    .wdt_timer1_timeout_serviced (wdt_timer1_timeout_serviced),
    .wdt_timer2_timeout_serviced (wdt_timer2_timeout_serviced)
);

// ==== mci_top.sv ====
`timescale 1ns/1ps
// MCI control register block, top level
// Connects the register port front end to the machine timer, the error
// aggregation and the firmware update request detector
module mci_top import mci_pkg::*; (
    input  logic                  clk,
    input  logic                  mci_rst_b,
    // Register port
    input  logic                  req,
    input  logic                  wr,
    input  logic [mci_addr_w-1:0] addr,
    input  logic [mci_data_w-1:0] wdata,
    input  logic [mci_strb_w-1:0] wstrb,
    output logic [mci_data_w-1:0] rdata,
    output logic                  err,
    // Watchdog
    input  logic                  t1_timeout,
    input  logic                  t2_timeout,
    input  logic                  t1_timeout_p,
    input  logic                  t2_timeout_p,
    output logic                  wdt_timer1_timeout_serviced,
    output logic                  wdt_timer2_timeout_serviced,
    // Error sources
    input  logic                  cptra_error_fatal,
    input  logic                  cptra_error_non_fatal,
    input  logic                  nmi_intr,
    input  logic                  mcu_sram_single_ecc_error,
    input  logic                  mcu_sram_double_ecc_error,
    input  logic                  mcu_sram_fw_exec_region_lock,
    // Interrupts and SoC errors
    output logic                  mci_intr,
    output logic                  mcu_timer_int,
    output logic                  mci_error_fatal,
    output logic                  mci_error_non_fatal
);

// Write broadcast from the port front end
mci_reg_e              reg_sel;
logic                  wr_pulse;
logic [mci_data_w-1:0] wr_data;
logic [mci_data_w-1:0] wr_biten;
// Read words back from the data blocks
logic [mci_data_w-1:0] mtime_rdata;
logic [mci_data_w-1:0] err_rdata;
logic                  rst_req;

//////////////////////////////////////////////////
// Port front end and interrupt registers
//////////////////////////////////////////////////
mci_csr u_csr (.*);

// Timer
mci_mtime u_mtime (.*);

// SoC error reporting
mci_err_agg u_err_agg (.*);

// MCU reset request on region lock edges
mci_fw_upd_fsm u_fw_upd_fsm (.*);

endmodule

// ==== mci_fw_upd_fsm.sv ====
`timescale 1ns/1ps
// Firmware update reset-request detector
// Watches the SRAM execution-region lock and issues a one-cycle MCU reset
// request on the first boot rise and on each hitless update fall
module mci_fw_upd_fsm import mci_pkg::*; (
    input  logic clk,
    input  logic mci_rst_b,
    input  logic mcu_sram_fw_exec_region_lock,
    output logic rst_req
);

fw_upd_e state_q;
fw_upd_e state_d;
logic    lock_q;
logic    lock_rise;
logic    lock_fall;
logic    req_d;

assign lock_rise = mcu_sram_fw_exec_region_lock & ~lock_q;
assign lock_fall = ~mcu_sram_fw_exec_region_lock & lock_q;

always_comb begin
    state_d = state_q;
    req_d   = 1'b0;
    case (state_q)
        // First boot, lock rise means an image is ready
        fw_boot_wait: if (lock_rise) begin
            req_d   = 1'b1;
            state_d = fw_running;
        end
        // Lock drop starts a hitless update
        fw_running: if (lock_fall) begin
            req_d   = 1'b1;
            state_d = fw_hitless_wait;
        end
        // Re-lock while MCU is held, no new request
        fw_hitless_wait: if (lock_rise) begin
            state_d = fw_running;
        end
        default: state_d = fw_boot_wait;
    endcase
end

always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        state_q <= fw_boot_wait;
        lock_q  <= 1'b0;
        rst_req <= 1'b0;
    end else begin
        state_q <= state_d;
        lock_q  <= mcu_sram_fw_exec_region_lock;
        rst_req <= req_d;
    end
end

endmodule

// ==== mci_err_agg.sv ====
`timescale 1ns/1ps
// MCI error aggregation
// Firmware, hardware and Caliptra error registers with their masks.
// A newly set unmasked bit raises the sticky fatal output or the
// non-fatal output, which drops once nothing unmasked is pending.
module mci_err_agg import mci_pkg::*; (
    input  logic                  clk,
    input  logic                  mci_rst_b,
    input  mci_reg_e              reg_sel,
    input  logic                  wr_pulse,
    input  logic [mci_data_w-1:0] wr_data,
    input  logic [mci_data_w-1:0] wr_biten,
    input  logic                  cptra_error_fatal,
    input  logic                  cptra_error_non_fatal,
    input  logic                  nmi_intr,
    input  logic                  mcu_sram_double_ecc_error,
    output logic [mci_data_w-1:0] err_rdata,
    output logic                  mci_error_fatal,
    output logic                  mci_error_non_fatal
);

// Bit 0 fatal, bit 1 non-fatal
logic [1:0]            cptra_sync1_q;
logic [1:0]            cptra_sync2_q;
logic [mci_data_w-1:0] fw_fatal_q;
logic [mci_data_w-1:0] fw_non_fatal_q;
logic [mci_data_w-1:0] fw_fatal_mask_q;
logic [mci_data_w-1:0] fw_non_fatal_mask_q;
// Bit 0 SRAM uncorrectable ECC, bit 1 NMI pin
logic [1:0]            hw_fatal_q;
logic [1:0]            agg_q;
// SRAM ECC, NMI, Caliptra fatal, Caliptra non-fatal
logic [3:0]            int_mask_q;
logic [mci_data_w-1:0] wr_ones;
logic [1:0]            hw_set;
logic [1:0]            hw_clr;
logic [1:0]            agg_clr;
logic                  fatal_new;
logic                  non_fatal_new;
logic                  non_fatal_pending;

//////////////////////////////////////////////////
// Caliptra error synchronizers
//////////////////////////////////////////////////
always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        cptra_sync1_q <= 2'b00;
        cptra_sync2_q <= 2'b00;
    end else begin
        cptra_sync1_q <= {cptra_error_non_fatal, cptra_error_fatal};
        cptra_sync2_q <= cptra_sync1_q;
    end
end

//////////////////////////////////////////////////
// Error registers
//////////////////////////////////////////////////
assign wr_ones = wr_data & wr_biten;
assign hw_set  = {nmi_intr, mcu_sram_double_ecc_error};
assign hw_clr  = (wr_pulse && reg_sel == hw_err_fatal) ? wr_ones[1:0] : 2'b00;
assign agg_clr = (wr_pulse && reg_sel == agg_err) ? wr_ones[1:0] : 2'b00;

always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        fw_fatal_q          <= '0;
        fw_non_fatal_q      <= '0;
        fw_fatal_mask_q     <= '0;
        fw_non_fatal_mask_q <= '0;
        hw_fatal_q          <= 2'b00;
        agg_q               <= 2'b00;
        int_mask_q          <= 4'h0;
    end else begin
        // Firmware error codes, a strobed one sets a clear bit or clears a set one
        if (wr_pulse && reg_sel == fw_err_fatal) begin
            fw_fatal_q <= fw_fatal_q ^ wr_ones;
        end
        if (wr_pulse && reg_sel == fw_err_non_fatal) begin
            fw_non_fatal_q <= fw_non_fatal_q ^ wr_ones;
        end
        if (wr_pulse && reg_sel == fw_fatal_mask) begin
            fw_fatal_mask_q <= merge_bytes(fw_fatal_mask_q, wr_data, wr_biten);
        end
        if (wr_pulse && reg_sel == fw_non_fatal_mask) begin
            fw_non_fatal_mask_q <= merge_bytes(fw_non_fatal_mask_q, wr_data, wr_biten);
        end
        if (wr_pulse && reg_sel == internal_mask) begin
            int_mask_q <= (int_mask_q & ~wr_biten[3:0]) | wr_ones[3:0];
        end
        // Hardware set beats the W1C clear
        hw_fatal_q <= (hw_fatal_q & ~hw_clr) | hw_set;
        agg_q      <= (agg_q & ~agg_clr) | cptra_sync2_q;
    end
end

//////////////////////////////////////////////////
// Fatal and non-fatal outputs
//////////////////////////////////////////////////

// New means the bit was clear before this edge
assign fatal_new =
    ((wr_pulse && reg_sel == fw_err_fatal) &&
     |(wr_ones & ~fw_fatal_q & ~fw_fatal_mask_q)) ||
    |(hw_set & ~hw_fatal_q & ~int_mask_q[1:0]) ||
    (cptra_sync2_q[0] && !agg_q[0] && !int_mask_q[2]);

assign non_fatal_new =
    ((wr_pulse && reg_sel == fw_err_non_fatal) &&
     |(wr_ones & ~fw_non_fatal_q & ~fw_non_fatal_mask_q)) ||
    (cptra_sync2_q[1] && !agg_q[1] && !int_mask_q[3]);

assign non_fatal_pending = |(fw_non_fatal_q & ~fw_non_fatal_mask_q) ||
                           (agg_q[1] && !int_mask_q[3]);

always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        mci_error_fatal     <= 1'b0;
        mci_error_non_fatal <= 1'b0;
    end else begin
        // Fatal is sticky until reset
        if (fatal_new) begin
            mci_error_fatal <= 1'b1;
        end
        if (non_fatal_new) begin
            mci_error_non_fatal <= 1'b1;
        end else if (!non_fatal_pending) begin
            mci_error_non_fatal <= 1'b0;
        end
    end
end

always_comb begin
    case (reg_sel)
        fw_err_fatal:      err_rdata = fw_fatal_q;
        fw_err_non_fatal:  err_rdata = fw_non_fatal_q;
        fw_fatal_mask:     err_rdata = fw_fatal_mask_q;
        fw_non_fatal_mask: err_rdata = fw_non_fatal_mask_q;
        hw_err_fatal:      err_rdata = {{(mci_data_w-2){1'b0}}, hw_fatal_q};
        agg_err:           err_rdata = {{(mci_data_w-2){1'b0}}, agg_q};
        internal_mask:     err_rdata = {{(mci_data_w-4){1'b0}}, int_mask_q};
        default:           err_rdata = '0;
    endcase
end

endmodule

// ==== mci_mtime.sv ====
`timescale 1ns/1ps
// MCU machine timer
// Free-running 64-bit count with a 64-bit compare value, both split into
// two word registers, and a level timer interrupt
module mci_mtime import mci_pkg::*; (
    input  logic                  clk,
    input  logic                  mci_rst_b,
    input  mci_reg_e              reg_sel,
    input  logic                  wr_pulse,
    input  logic [mci_data_w-1:0] wr_data,
    input  logic [mci_data_w-1:0] wr_biten,
    output logic [mci_data_w-1:0] mtime_rdata,
    output logic                  mcu_timer_int
);

logic [mci_mtime_w-1:0] mtime_q;
logic [mci_mtime_w-1:0] mtime_d;
logic [mci_mtime_w-1:0] mtimecmp_q;
logic [mci_mtime_w-1:0] mtimecmp_d;

// Software write to either count half replaces the increment
always_comb begin
    mtime_d    = mtime_q + mci_mtime_w'(1);
    mtimecmp_d = mtimecmp_q;
    if (wr_pulse) begin
        case (reg_sel)
            mtime_l: mtime_d = {mtime_q[mci_mtime_w-1:mci_data_w],
                                merge_bytes(mtime_q[mci_data_w-1:0], wr_data, wr_biten)};
            mtime_h: mtime_d = {merge_bytes(mtime_q[mci_mtime_w-1:mci_data_w],
                                            wr_data, wr_biten),
                                mtime_q[mci_data_w-1:0]};
            mtimecmp_l: mtimecmp_d[mci_data_w-1:0] =
                merge_bytes(mtimecmp_q[mci_data_w-1:0], wr_data, wr_biten);
            mtimecmp_h: mtimecmp_d[mci_mtime_w-1:mci_data_w] =
                merge_bytes(mtimecmp_q[mci_mtime_w-1:mci_data_w], wr_data, wr_biten);
            default: ;
        endcase
    end
end

always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        mtime_q    <= '0;
        // All ones keeps the interrupt quiet until software programs it
        mtimecmp_q <= '1;
    end else begin
        mtime_q    <= mtime_d;
        mtimecmp_q <= mtimecmp_d;
    end
end

// Full-width compare, no carry timing between halves
assign mcu_timer_int = mtime_q >= mtimecmp_q;

always_comb begin
    case (reg_sel)
        mtime_l:    mtime_rdata = mtime_q[mci_data_w-1:0];
        mtime_h:    mtime_rdata = mtime_q[mci_mtime_w-1:mci_data_w];
        mtimecmp_l: mtime_rdata = mtimecmp_q[mci_data_w-1:0];
        mtimecmp_h: mtime_rdata = mtimecmp_q[mci_mtime_w-1:mci_data_w];
        default:    mtime_rdata = '0;
    endcase
end

endmodule

// ==== mci_csr.sv ====
`timescale 1ns/1ps
// MCI register port front end
// Decodes the single-cycle request, flags unmapped offsets, expands byte
// strobes and broadcasts writes to the data blocks. Holds the internal
// interrupt status/enable pair, the registered interrupt output and the
// watchdog serviced pulses, and muxes the read data.
module mci_csr import mci_pkg::*; (
    input  logic                  clk,
    input  logic                  mci_rst_b,
    input  logic                  req,
    input  logic                  wr,
    input  logic [mci_addr_w-1:0] addr,
    input  logic [mci_data_w-1:0] wdata,
    input  logic [mci_strb_w-1:0] wstrb,
    input  logic                  t1_timeout,
    input  logic                  t2_timeout,
    input  logic                  t1_timeout_p,
    input  logic                  t2_timeout_p,
    input  logic                  mcu_sram_single_ecc_error,
    input  logic                  rst_req,
    input  logic [mci_data_w-1:0] mtime_rdata,
    input  logic [mci_data_w-1:0] err_rdata,
    output mci_reg_e              reg_sel,
    output logic                  wr_pulse,
    output logic [mci_data_w-1:0] wr_data,
    output logic [mci_data_w-1:0] wr_biten,
    output logic [mci_data_w-1:0] rdata,
    output logic                  err,
    output logic                  mci_intr,
    output logic                  wdt_timer1_timeout_serviced,
    output logic                  wdt_timer2_timeout_serviced
);

logic                  mapped;
logic [mci_intr_w-1:0] intr_sts_q;
logic [mci_intr_w-1:0] intr_en_q;
logic [mci_intr_w-1:0] intr_hw_set;
logic [mci_intr_w-1:0] intr_clr;
logic [1:0]            wdt_sts_prev_q;
logic [mci_data_w-1:0] rdata_sel;

//////////////////////////////////////////////////
// Address decode
//////////////////////////////////////////////////

// Only listed offsets are mapped, which also rejects unaligned ones
always_comb begin
    case (addr)
        fw_err_fatal, fw_err_non_fatal, fw_fatal_mask, fw_non_fatal_mask,
        hw_err_fatal, agg_err, internal_mask, intr_sts, intr_en,
        mtime_l, mtime_h, mtimecmp_l, mtimecmp_h, wdt_status: mapped = 1'b1;
        default: mapped = 1'b0;
    endcase
end

assign reg_sel  = mci_reg_e'(addr);
assign err      = req & ~mapped;
// Unmapped writes never reach the data blocks
assign wr_pulse = req & wr & mapped;
assign wr_data  = wdata;

// One strobe covers one byte lane
always_comb begin
    for (int b = 0; b < mci_strb_w; b++) begin
        wr_biten[b*8 +: 8] = {8{wstrb[b]}};
    end
end

//////////////////////////////////////////////////
// Internal interrupts
//////////////////////////////////////////////////
assign intr_hw_set[intr_wdt1_bit]    = t1_timeout_p;
assign intr_hw_set[intr_wdt2_bit]    = t2_timeout_p;
assign intr_hw_set[intr_rst_req_bit] = rst_req;
assign intr_hw_set[intr_ecc_cor_bit] = mcu_sram_single_ecc_error;

// W1C on strobed bytes only
assign intr_clr = (wr_pulse && reg_sel == intr_sts) ?
                  (wr_data[mci_intr_w-1:0] & wr_biten[mci_intr_w-1:0]) : '0;

always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        intr_sts_q <= '0;
        intr_en_q  <= '0;
        mci_intr   <= 1'b0;
    end else begin
        // Hardware set wins over a same-cycle clear
        intr_sts_q <= (intr_sts_q & ~intr_clr) | intr_hw_set;
        if (wr_pulse && reg_sel == intr_en) begin
            intr_en_q <= (intr_en_q & ~wr_biten[mci_intr_w-1:0]) |
                         (wr_data[mci_intr_w-1:0] & wr_biten[mci_intr_w-1:0]);
        end
        mci_intr <= |(intr_sts_q & intr_en_q);
    end
end

//////////////////////////////////////////////////
// Watchdog serviced detect
//////////////////////////////////////////////////

// Falling status bit means software has acknowledged the timeout
always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
        wdt_sts_prev_q <= 2'b00;
    end else begin
        wdt_sts_prev_q <= {intr_sts_q[intr_wdt2_bit], intr_sts_q[intr_wdt1_bit]};
    end
end

assign wdt_timer1_timeout_serviced = wdt_sts_prev_q[0] & ~intr_sts_q[intr_wdt1_bit];
assign wdt_timer2_timeout_serviced = wdt_sts_prev_q[1] & ~intr_sts_q[intr_wdt2_bit];

// Read mux, local registers first, then the data blocks
always_comb begin
    case (reg_sel)
        intr_sts:   rdata_sel = {{(mci_data_w-mci_intr_w){1'b0}}, intr_sts_q};
        intr_en:    rdata_sel = {{(mci_data_w-mci_intr_w){1'b0}}, intr_en_q};
        // Live watchdog levels, read only
        wdt_status: rdata_sel = {{(mci_data_w-2){1'b0}}, t2_timeout, t1_timeout};
        mtime_l, mtime_h, mtimecmp_l, mtimecmp_h: rdata_sel = mtime_rdata;
        default:    rdata_sel = err_rdata;
    endcase
    rdata = mapped ? rdata_sel : '0;
end

endmodule

// ==== mci_pkg.sv ====
// MCI control register package
// Bus widths, register offsets, interrupt bit positions and the
// firmware update state encoding shared by the register block
package mci_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int mci_data_w  = 32;
    localparam int mci_addr_w  = 8;
    localparam int mci_strb_w  = mci_data_w / 8;
    localparam int mci_mtime_w = 2 * mci_data_w;
    localparam int mci_intr_w  = 4;

    // Register byte offsets, word aligned
    typedef enum logic [mci_addr_w-1:0] {
        fw_err_fatal      = 8'h00,
        fw_err_non_fatal  = 8'h04,
        fw_fatal_mask     = 8'h08,
        fw_non_fatal_mask = 8'h0C,
        hw_err_fatal      = 8'h10,
        agg_err           = 8'h14,
        internal_mask     = 8'h18,
        intr_sts          = 8'h1C,
        intr_en           = 8'h20,
        mtime_l           = 8'h24,
        mtime_h           = 8'h28,
        mtimecmp_l        = 8'h2C,
        mtimecmp_h        = 8'h30,
        wdt_status        = 8'h34
    } mci_reg_e;

    // Bit positions in intr_sts and intr_en
    localparam int intr_wdt1_bit    = 0;
    localparam int intr_wdt2_bit    = 1;
    localparam int intr_rst_req_bit = 2;
    localparam int intr_ecc_cor_bit = 3;

    // Firmware update tracking
    typedef enum logic [1:0] {
        fw_boot_wait,
        fw_running,
        fw_hitless_wait
    } fw_upd_e;

    // Byte-enabled update of one register word
    function automatic logic [mci_data_w-1:0] merge_bytes(
        input logic [mci_data_w-1:0] cur,
        input logic [mci_data_w-1:0] wval,
        input logic [mci_data_w-1:0] biten
    );
        return (cur & ~biten) | (wval & biten);
    endfunction

endpackage
